// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100
SOURCES   := $(wildcard hdl/*.sv verification/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIMFLAGS"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder import bus_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_stb,
    input  addr_t i_adr,
    // responder returns
    input  logic  i_mem_ack,
    input  logic  i_sys_ack,
    input  logic  i_swled_ack,
    input  data_t i_mem_dat,
    input  data_t i_sys_dat,
    input  data_t i_swled_dat,
    // qualified strobes
    output logic  o_mem_stb,
    output logic  o_sys_stb,
    output logic  o_swled_stb,
    // merged response
    output logic  o_ack,
    output logic  o_err,
    output data_t o_dat,
    output addr_t o_err_adr
);

    logic  mem_sel;
    logic  sys_sel;
    logic  swled_sel;
    logic  none_sel;
    logic  r_err_p;
    addr_t r_err_adr_p;

    // region match
    assign mem_sel   = (i_adr[REGION_MSB:REGION_LSB] == MEM_REGION);
    assign sys_sel   = (i_adr[REGION_MSB:REGION_LSB] == SYSREG_REGION);
    assign swled_sel = (i_adr == SW_LED_ADDR);
    assign none_sel  = !mem_sel && !sys_sel && !swled_sel;

    assign o_mem_stb   = i_stb && mem_sel;
    assign o_sys_stb   = i_stb && sys_sel;
    assign o_swled_stb = i_stb && swled_sel;

    // err runs through two stages to line up with the responder acks
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_err_p <= 1'b0;
            o_err   <= 1'b0;
            o_ack   <= 1'b0;
        end else begin
            r_err_p <= i_stb && none_sel;
            o_err   <= r_err_p;
            o_ack   <= i_mem_ack || i_sys_ack || i_swled_ack;
        end
    end

    // address of the failing strobe, follows the err pipeline
    always_ff @(posedge i_clk) begin
        if (i_stb && none_sel)
            r_err_adr_p <= i_adr;
        if (r_err_p)
            o_err_adr <= r_err_adr_p;
    end

    // at most one responder acks in any cycle
    always_ff @(posedge i_clk) begin
        if (i_mem_ack)
            o_dat <= i_mem_dat;
        else if (i_sys_ack)
            o_dat <= i_sys_dat;
        else if (i_swled_ack)
            o_dat <= i_swled_dat;
        else
            o_dat <= '0;
    end

endmodule : bus_decoder

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    // wishbone word addressing, 32-bit data
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // top address bits pick the region
    localparam int REGION_MSB = 29;
    localparam int REGION_LSB = 21;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    // 8MB of ram at the bottom of the map
    localparam logic [REGION_W-1:0] MEM_REGION    = 9'd0;
    // system registers in the next 8MB block
    localparam logic [REGION_W-1:0] SYSREG_REGION = 9'd1;

    // single word for the switch/led port
    localparam addr_t SW_LED_ADDR = 30'h400001;

endpackage : bus_pkg

// ==== hdl/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import bus_pkg::*; #(
    parameter int MEM_AW = 10
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_stb,
    input  logic              i_we,
    input  logic [MEM_AW-1:0] i_adr,
    input  data_t             i_dat,
    input  sel_t              i_sel,
    output logic              o_ack,
    output data_t             o_dat
);

    data_t mem [2**MEM_AW];

    // byte lanes written only where selected
    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (i_sel[i])
                    mem[i_adr][8*i +: 8] <= i_dat[8*i +: 8];
            end
        end
        // old contents come back, writes included
        if (i_stb)
            o_dat <= mem[i_adr];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_ack <= 1'b0;
        else
            o_ack <= i_stb;
    end

endmodule : scratch_ram

// ==== hdl/soc_bus_fabric.sv ====
`timescale 1ns/1ps

module soc_bus_fabric import bus_pkg::*, sysreg_pkg::*; #(
    parameter int MEM_AW = 10
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    // master a, cpu side
    input  logic        i_a_cyc,
    input  logic        i_a_stb,
    input  logic        i_a_we,
    input  addr_t       i_a_adr,
    input  data_t       i_a_dat,
    input  sel_t        i_a_sel,
    output logic        o_a_ack,
    output logic        o_a_err,
    output logic        o_a_stall,
    // master b, debug side
    input  logic        i_b_cyc,
    input  logic        i_b_stb,
    input  logic        i_b_we,
    input  addr_t       i_b_adr,
    input  data_t       i_b_dat,
    input  sel_t        i_b_sel,
    output logic        o_b_ack,
    output logic        o_b_err,
    output logic        o_b_stall,
    // shared read data
    output data_t       o_dat,
    input  logic [15:0] i_switches,
    output logic [15:0] o_leds,
    output logic        o_irq
);

    logic  bus_stb, bus_we, bus_ack, bus_err;
    addr_t bus_adr;
    data_t bus_dat;
    sel_t  bus_sel;
    addr_t err_adr;

    logic  mem_stb, sys_stb, swled_stb;
    logic  mem_ack, sys_ack, swled_ack;
    data_t mem_dat, sys_dat, swled_dat;

    wb_priority_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_a_cyc   (i_a_cyc),
        .i_a_stb   (i_a_stb),
        .i_a_we    (i_a_we),
        .i_a_adr   (i_a_adr),
        .i_a_dat   (i_a_dat),
        .i_a_sel   (i_a_sel),
        .o_a_ack   (o_a_ack),
        .o_a_err   (o_a_err),
        .o_a_stall (o_a_stall),
        .i_b_cyc   (i_b_cyc),
        .i_b_stb   (i_b_stb),
        .i_b_we    (i_b_we),
        .i_b_adr   (i_b_adr),
        .i_b_dat   (i_b_dat),
        .i_b_sel   (i_b_sel),
        .o_b_ack   (o_b_ack),
        .o_b_err   (o_b_err),
        .o_b_stall (o_b_stall),
        // responders decode on the qualified stb alone
        .o_cyc     (),
        .o_stb     (bus_stb),
        .o_we      (bus_we),
        .o_adr     (bus_adr),
        .o_dat     (bus_dat),
        .o_sel     (bus_sel),
        .i_ack     (bus_ack),
        .i_err     (bus_err)
    );

    bus_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stb       (bus_stb),
        .i_adr       (bus_adr),
        .i_mem_ack   (mem_ack),
        .i_sys_ack   (sys_ack),
        .i_swled_ack (swled_ack),
        .i_mem_dat   (mem_dat),
        .i_sys_dat   (sys_dat),
        .i_swled_dat (swled_dat),
        .o_mem_stb   (mem_stb),
        .o_sys_stb   (sys_stb),
        .o_swled_stb (swled_stb),
        .o_ack       (bus_ack),
        .o_err       (bus_err),
        .o_dat       (o_dat),
        .o_err_adr   (err_adr)
    );

    // ram aliases every 2**MEM_AW words
    scratch_ram #(
        .MEM_AW (MEM_AW)
    ) u_ram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_stb   (mem_stb),
        .i_we    (bus_we),
        .i_adr   (bus_adr[MEM_AW-1:0]),
        .i_dat   (bus_dat),
        .i_sel   (bus_sel),
        .o_ack   (mem_ack),
        .o_dat   (mem_dat)
    );

    sysreg_block u_sysreg (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_stb     (sys_stb),
        .i_we      (bus_we),
        .i_off     (bus_adr[SYSREG_OFF_W-1:0]),
        .i_dat     (bus_dat),
        .i_err     (bus_err),
        .i_err_adr (err_adr),
        .o_ack     (sys_ack),
        .o_dat     (sys_dat),
        .o_irq     (o_irq)
    );

    switch_led_port u_swled (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stb      (swled_stb),
        .i_we       (bus_we),
        .i_dat      (bus_dat),
        .i_switches (i_switches),
        .o_ack      (swled_ack),
        .o_dat      (swled_dat),
        .o_leds     (o_leds)
    );

endmodule : soc_bus_fabric

// ==== hdl/switch_led_port.sv ====
`timescale 1ns/1ps

module switch_led_port import bus_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_stb,
    input  logic        i_we,
    input  data_t       i_dat,
    input  logic [15:0] i_switches,
    output logic        o_ack,
    output data_t       o_dat,
    output logic [15:0] o_leds
);

    // led register, loaded from the low half
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_leds <= '0;
            o_ack  <= 1'b0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we)
                o_leds <= i_dat[15:0];
        end
    end

    // switches high, leds low
    always_ff @(posedge i_clk) begin
        if (i_stb)
            o_dat <= {i_switches, o_leds};
    end

endmodule : switch_led_port

// ==== hdl/sysreg_block.sv ====
`timescale 1ns/1ps

module sysreg_block import bus_pkg::*, sysreg_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_stb,
    input  logic        i_we,
    input  sysreg_off_t i_off,
    input  data_t       i_dat,
    // error report from the decoder
    input  logic        i_err,
    input  addr_t       i_err_adr,
    output logic        o_ack,
    output data_t       o_dat,
    output logic        o_irq
);

    data_t r_scratch;
    data_t r_power;
    addr_t r_bus_err;

    // writable registers
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_irq <= 1'b0;
        end else if (i_stb && i_we && i_off == REG_IRQ) begin
            o_irq <= i_dat[0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb && i_we && i_off == REG_SCRATCH)
            r_scratch <= i_dat;
    end

    // last errored word address
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            r_bus_err <= '0;
        else if (i_err)
            r_bus_err <= i_err_adr;
    end

    // cycles since reset, top bit sticks once reached
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            r_power <= '0;
        else if (!r_power[DATA_W-1])
            r_power <= r_power + 1'b1;
        else
            r_power[DATA_W-2:0] <= r_power[DATA_W-2:0] + 1'b1;
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (i_off)
                REG_ID:      o_dat <= SYS_ID;
                REG_SCRATCH: o_dat <= r_scratch;
                REG_BUSERR:  o_dat <= {r_bus_err, 2'b00};
                REG_POWER:   o_dat <= r_power;
                REG_IRQ:     o_dat <= {{(DATA_W-1){1'b0}}, o_irq};
                default:     o_dat <= '0;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_ack <= 1'b0;
        else
            o_ack <= i_stb;
    end

endmodule : sysreg_block

// ==== hdl/sysreg_pkg.sv ====
package sysreg_pkg;

    // register offset taken from the low word-address bits
    localparam int SYSREG_OFF_W = 4;

    typedef logic [SYSREG_OFF_W-1:0] sysreg_off_t;

    localparam sysreg_off_t REG_ID      = 4'd0;
    localparam sysreg_off_t REG_SCRATCH = 4'd1;
    localparam sysreg_off_t REG_BUSERR  = 4'd2;
    localparam sysreg_off_t REG_POWER   = 4'd3;
    localparam sysreg_off_t REG_IRQ     = 4'd4;

    // read-only identification word
    localparam logic [31:0] SYS_ID = 32'h20191028;

endpackage : sysreg_pkg

// ==== hdl/wb_priority_arbiter.sv ====
`timescale 1ns/1ps

module wb_priority_arbiter import bus_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    // master a, the priority port
    input  logic  i_a_cyc,
    input  logic  i_a_stb,
    input  logic  i_a_we,
    input  addr_t i_a_adr,
    input  data_t i_a_dat,
    input  sel_t  i_a_sel,
    output logic  o_a_ack,
    output logic  o_a_err,
    output logic  o_a_stall,
    // master b
    input  logic  i_b_cyc,
    input  logic  i_b_stb,
    input  logic  i_b_we,
    input  addr_t i_b_adr,
    input  data_t i_b_dat,
    input  sel_t  i_b_sel,
    output logic  o_b_ack,
    output logic  o_b_err,
    output logic  o_b_stall,
    // merged bus
    output logic  o_cyc,
    output logic  o_stb,
    output logic  o_we,
    output addr_t o_adr,
    output data_t o_dat,
    output sel_t  o_sel,
    input  logic  i_ack,
    input  logic  i_err
);

    logic r_a_owner;

    // ownership only moves once the current owner has dropped cyc
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_a_owner <= 1'b1;
        end else if (r_a_owner) begin
            if (!i_a_cyc && i_b_cyc)
                r_a_owner <= 1'b0;
        end else if (!i_b_cyc) begin
            // idle bus falls back to a
            r_a_owner <= 1'b1;
        end
    end

    // owner's request onto the merged bus
    assign o_cyc = r_a_owner ? i_a_cyc : i_b_cyc;
    assign o_stb = r_a_owner ? (i_a_cyc && i_a_stb) : (i_b_cyc && i_b_stb);
    assign o_we  = r_a_owner ? i_a_we  : i_b_we;
    assign o_adr = r_a_owner ? i_a_adr : i_b_adr;
    assign o_dat = r_a_owner ? i_a_dat : i_b_dat;
    assign o_sel = r_a_owner ? i_a_sel : i_b_sel;

    // responders never stall, so only the loser waits
    assign o_a_stall = !r_a_owner && i_a_stb;
    assign o_b_stall = r_a_owner && i_b_stb;

    // responses go back to the owner only
    assign o_a_ack = r_a_owner && i_ack;
    assign o_a_err = r_a_owner && i_err;
    assign o_b_ack = !r_a_owner && i_ack;
    assign o_b_err = !r_a_owner && i_err;

endmodule : wb_priority_arbiter

// ==== verification/soc_bus_properties.sv ====
`timescale 1ns/1ps

module soc_bus_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_cyc,
    input logic i_a_stb,
    input logic i_b_stb,
    input logic i_a_stall,
    input logic i_b_stall,
    input logic i_a_ack,
    input logic i_b_ack,
    input logic i_a_err,
    input logic i_b_err
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    one_owner_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_a_ack && i_b_ack))
    else begin
        fail_count++;
        $error("ack routed to both masters");
    end

    ack_err_apart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !((i_a_ack && i_a_err) || (i_b_ack && i_b_err)))
    else begin
        fail_count++;
        $error("ack and err raised together");
    end

    // first cycle out of reset
    idle_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_cyc)
    else begin
        fail_count++;
        $error("merged cyc high right after reset");
    end

    // two strobing masters, only one of them may go through
    stall_loser: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_a_stb && i_b_stb) |-> (i_a_stall != i_b_stall))
    else begin
        fail_count++;
        $error("strobing non-owner was not stalled");
    end

endmodule : soc_bus_properties

bind wb_priority_arbiter soc_bus_properties u_arb_props (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_cyc     (o_cyc),
    .i_a_stb   (i_a_stb),
    .i_b_stb   (i_b_stb),
    .i_a_stall (o_a_stall),
    .i_b_stall (o_b_stall),
    .i_a_ack   (o_a_ack),
    .i_b_ack   (o_b_ack),
    .i_a_err   (o_a_err),
    .i_b_err   (o_b_err)
);

// ==== verification/soc_bus_tb.sv ====
`timescale 1ns/1ps

module soc_bus_tb import bus_pkg::*, sysreg_pkg::*; ();

    localparam int   CLK_PERIOD   = 100;
    localparam int   RESET_CYCLES = 8;
    localparam int   MEM_AW       = 10;
    localparam int   LATENCY      = 2;
    localparam int   SEED         = 32'h8c70;
    // watchdog budget per transfer
    localparam int   XFER_CYCLES  = 20;
    // two power reads and the two racing masters
    localparam int   EXTRA_XFERS  = 4;
    localparam logic MST_A        = 1'b0;
    localparam logic MST_B        = 1'b1;

    typedef enum logic {RESP_ACK, RESP_ERR} resp_t;

    typedef struct {
        logic  master;
        logic  we;
        addr_t adr;
        data_t dat;
        sel_t  sel;
        resp_t kind;
        logic  chk;
        data_t exp;
    } xfer_t;

    logic        clk;
    logic        rst_n;
    logic        a_cyc, a_stb, a_we, a_ack, a_err, a_stall;
    logic        b_cyc, b_stb, b_we, b_ack, b_err, b_stall;
    addr_t       a_adr, b_adr;
    data_t       a_dat, b_dat;
    sel_t        a_sel, b_sel;
    data_t       rd_dat;
    logic [15:0] switches;
    logic [15:0] leds;
    logic        irq;

    xfer_t tbl[$];
    data_t scratch_word;

    soc_bus_fabric #(
        .MEM_AW (MEM_AW)
    ) dut0 (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_a_cyc    (a_cyc),
        .i_a_stb    (a_stb),
        .i_a_we     (a_we),
        .i_a_adr    (a_adr),
        .i_a_dat    (a_dat),
        .i_a_sel    (a_sel),
        .o_a_ack    (a_ack),
        .o_a_err    (a_err),
        .o_a_stall  (a_stall),
        .i_b_cyc    (b_cyc),
        .i_b_stb    (b_stb),
        .i_b_we     (b_we),
        .i_b_adr    (b_adr),
        .i_b_dat    (b_dat),
        .i_b_sel    (b_sel),
        .o_b_ack    (b_ack),
        .o_b_err    (b_err),
        .o_b_stall  (b_stall),
        .o_dat      (rd_dat),
        .i_switches (switches),
        .o_leds     (leds),
        .o_irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic watchdog(int cycles);
        #(cycles * CLK_PERIOD);
        fail_run($sformatf("timeout: the run did not finish within %0d cycles", cycles));
    endtask

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_resp(string name, resp_t got, resp_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h (%s), expected 0x%h (%s)",
                               name, got, got.name(), exp, exp.name()));
    endtask

    task automatic check_leds(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_latency(string name, int got, int exp);
        if (got != exp)
            fail_run($sformatf("Mismatch %s: got 0x%h cycles, expected 0x%h", name, got, exp));
    endtask

    // word address of a system register
    function automatic addr_t sys_adr(sysreg_off_t off);
        addr_t adr;
        adr = '0;
        adr[REGION_MSB:REGION_LSB] = SYSREG_REGION;
        adr[SYSREG_OFF_W-1:0] = off;
        return adr;
    endfunction

    // byte lanes of new_word replace old_word where selected
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, sel_t sel);
        data_t res;
        res = old_word;
        for (int i = 0; i < SEL_W; i++) begin
            if (sel[i])
                res[8*i +: 8] = new_word[8*i +: 8];
        end
        return res;
    endfunction

    function automatic void add_entry(logic m, logic we, addr_t adr, data_t dat, sel_t sel,
                                      resp_t kind, logic chk, data_t exp);
        xfer_t e;
        e = '{m, we, adr, dat, sel, kind, chk, exp};
        tbl.push_back(e);
    endfunction

    function automatic void build_table();
        data_t d0;
        data_t d1;
        data_t d2;
        data_t d3;
        data_t ram_word;
        data_t led_word;
        addr_t bad0;
        addr_t bad1;
        d0 = $urandom();
        d1 = $urandom();
        d2 = $urandom();
        d3 = $urandom();
        led_word = $urandom();
        scratch_word = $urandom();
        // ram, full words and byte lanes
        add_entry(MST_A, 1'b1, 30'h10, d0, 4'hf, RESP_ACK, 1'b0, '0);
        add_entry(MST_A, 1'b0, 30'h10, '0, 4'hf, RESP_ACK, 1'b1, d0);
        add_entry(MST_A, 1'b1, 30'h11, d1, 4'hf, RESP_ACK, 1'b0, '0);
        add_entry(MST_A, 1'b1, 30'h11, d2, 4'b0101, RESP_ACK, 1'b0, '0);
        ram_word = merge_bytes(d1, d2, 4'b0101);
        add_entry(MST_A, 1'b0, 30'h11, '0, 4'hf, RESP_ACK, 1'b1, ram_word);
        add_entry(MST_B, 1'b1, 30'h11, d3, 4'b1000, RESP_ACK, 1'b0, '0);
        ram_word = merge_bytes(ram_word, d3, 4'b1000);
        add_entry(MST_B, 1'b0, 30'h11, '0, 4'hf, RESP_ACK, 1'b1, ram_word);
        // same word one ram size higher
        add_entry(MST_A, 1'b0, addr_t'(32'h11 + (32'd1 << MEM_AW)), '0, 4'hf,
                  RESP_ACK, 1'b1, ram_word);
        // system registers
        add_entry(MST_A, 1'b0, sys_adr(REG_ID), '0, 4'hf, RESP_ACK, 1'b1, SYS_ID);
        add_entry(MST_B, 1'b1, sys_adr(REG_SCRATCH), scratch_word, 4'hf, RESP_ACK, 1'b0, '0);
        add_entry(MST_A, 1'b0, sys_adr(REG_SCRATCH), '0, 4'hf, RESP_ACK, 1'b1, scratch_word);
        add_entry(MST_A, 1'b1, sys_adr(REG_IRQ), 32'h1, 4'hf, RESP_ACK, 1'b0, '0);
        add_entry(MST_A, 1'b0, sys_adr(REG_IRQ), '0, 4'hf, RESP_ACK, 1'b1, 32'h1);
        add_entry(MST_A, 1'b1, sys_adr(REG_ID), 32'hffff_ffff, 4'hf, RESP_ACK, 1'b0, '0);
        add_entry(MST_A, 1'b0, sys_adr(REG_ID), '0, 4'hf, RESP_ACK, 1'b1, SYS_ID);
        add_entry(MST_A, 1'b1, sys_adr(REG_IRQ), 32'h0, 4'hf, RESP_ACK, 1'b0, '0);
        add_entry(MST_A, 1'b0, sys_adr(4'd9), '0, 4'hf, RESP_ACK, 1'b1, '0);
        // region 3 has no device
        bad0 = addr_t'($urandom());
        bad0[REGION_MSB:REGION_LSB] = 9'd3;
        add_entry(MST_A, 1'b0, bad0, '0, 4'hf, RESP_ERR, 1'b0, '0);
        add_entry(MST_A, 1'b0, sys_adr(REG_BUSERR), '0, 4'hf, RESP_ACK, 1'b1,
                  data_t'(bad0) * 32'd4);
        bad1 = SW_LED_ADDR + 1'b1;
        add_entry(MST_B, 1'b1, bad1, d0, 4'hf, RESP_ERR, 1'b0, '0);
        add_entry(MST_B, 1'b0, sys_adr(REG_BUSERR), '0, 4'hf, RESP_ACK, 1'b1,
                  data_t'(bad1) * 32'd4);
        // switch/led port
        add_entry(MST_A, 1'b1, SW_LED_ADDR, led_word, 4'hf, RESP_ACK, 1'b0, '0);
        add_entry(MST_B, 1'b0, SW_LED_ADDR, '0, 4'hf, RESP_ACK, 1'b1,
                  {switches, led_word[15:0]});
    endfunction

    task automatic drive(logic m, logic cyc, logic stb, logic we, addr_t adr, data_t dat,
                         sel_t sel);
        if (m == MST_A) begin
            a_cyc = cyc;
            a_stb = stb;
            a_we  = we;
            a_adr = adr;
            a_dat = dat;
            a_sel = sel;
        end else begin
            b_cyc = cyc;
            b_stb = stb;
            b_we  = we;
            b_adr = adr;
            b_dat = dat;
            b_sel = sel;
        end
    endtask

    function automatic logic stall_of(logic m);
        return (m == MST_A) ? a_stall : b_stall;
    endfunction

    function automatic logic ack_of(logic m);
        return (m == MST_A) ? a_ack : b_ack;
    endfunction

    function automatic logic err_of(logic m);
        return (m == MST_A) ? a_err : b_err;
    endfunction

    // one strobe, waits for acceptance then for ack or err
    task automatic bus_xfer(input logic m, input logic we, input addr_t adr, input data_t dat,
                            input sel_t sel, output resp_t kind, output data_t rdat,
                            output int lat, output int n_stall, output time t_acc,
                            output time t_resp);
        n_stall = 0;
        @(negedge clk);
        drive(m, 1'b1, 1'b1, we, adr, dat, sel);
        #(CLK_PERIOD / 4);
        while (stall_of(m)) begin
            n_stall++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        @(posedge clk);
        t_acc = $time;
        @(negedge clk);
        drive(m, 1'b1, 1'b0, we, adr, dat, sel);
        lat = 1;
        while (!ack_of(m) && !err_of(m)) begin
            @(negedge clk);
            lat++;
        end
        kind = err_of(m) ? RESP_ERR : RESP_ACK;
        rdat = rd_dat;
        t_resp = $time;
        drive(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    initial begin : main
        resp_t kind;
        data_t rdat;
        int    lat;
        int    n_stall;
        time   t_acc;
        time   t_resp;
        int    wd_cycles;
        resp_t pair_kind[2];
        data_t pair_dat[2];
        int    pair_lat[2];
        int    pair_stall[2];
        time   pair_acc[2];
        time   pair_resp[2];

        drive(MST_A, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive(MST_B, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        rst_n = 1'b0;
        void'($urandom(SEED));
        switches = 16'($urandom());
        build_table();
        wd_cycles = RESET_CYCLES + XFER_CYCLES * (tbl.size() + EXTRA_XFERS);
        fork
            watchdog(wd_cycles);
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("o_irq", irq, 1'b0);
        check_leds("o_leds", leds, 16'h0000);
        check_bit("o_a_ack", a_ack, 1'b0);
        check_bit("o_a_err", a_err, 1'b0);
        check_bit("o_b_ack", b_ack, 1'b0);
        check_bit("o_b_err", b_err, 1'b0);

        foreach (tbl[i]) begin
            bus_xfer(tbl[i].master, tbl[i].we, tbl[i].adr, tbl[i].dat, tbl[i].sel,
                     kind, rdat, lat, n_stall, t_acc, t_resp);
            check_resp($sformatf("response (entry %0d)", i), kind, tbl[i].kind);
            check_latency($sformatf("ack latency (entry %0d)", i), lat, LATENCY);
            if (tbl[i].chk)
                check_data($sformatf("o_dat (entry %0d)", i), rdat, tbl[i].exp);
            if (tbl[i].we && tbl[i].kind == RESP_ACK) begin
                if (tbl[i].adr == SW_LED_ADDR)
                    check_leds("o_leds", leds, tbl[i].dat[15:0]);
                if (tbl[i].adr == sys_adr(REG_IRQ))
                    check_bit("o_irq", irq, tbl[i].dat[0]);
            end
        end

        // power counter advances once per cycle between the two reads
        for (int k = 0; k < 2; k++) begin
            bus_xfer(k[0], 1'b0, sys_adr(REG_POWER), '0, 4'hf, pair_kind[k], pair_dat[k],
                     pair_lat[k], pair_stall[k], pair_acc[k], pair_resp[k]);
            check_resp("power read response", pair_kind[k], RESP_ACK);
            check_latency("power read latency", pair_lat[k], LATENCY);
        end
        if (pair_dat[1] <= pair_dat[0])
            fail_run($sformatf("power counter did not increase: 0x%h then 0x%h",
                               pair_dat[0], pair_dat[1]));
        check_data("o_dat power delta", pair_dat[1] - pair_dat[0],
                   data_t'((pair_acc[1] - pair_acc[0]) / CLK_PERIOD));

        // both masters raise cyc in the same idle cycle
        fork
            bus_xfer(MST_A, 1'b0, sys_adr(REG_ID), '0, 4'hf, pair_kind[0], pair_dat[0],
                     pair_lat[0], pair_stall[0], pair_acc[0], pair_resp[0]);
            bus_xfer(MST_B, 1'b0, sys_adr(REG_SCRATCH), '0, 4'hf, pair_kind[1], pair_dat[1],
                     pair_lat[1], pair_stall[1], pair_acc[1], pair_resp[1]);
        join
        check_resp("master a response", pair_kind[0], RESP_ACK);
        check_resp("master b response", pair_kind[1], RESP_ACK);
        check_data("o_dat master a", pair_dat[0], SYS_ID);
        check_data("o_dat master b", pair_dat[1], scratch_word);
        check_latency("master a latency", pair_lat[0], LATENCY);
        check_latency("master b latency", pair_lat[1], LATENCY);
        if (pair_stall[0] != 0)
            fail_run("master a was stalled although it had priority");
        if (pair_stall[1] == 0)
            fail_run("master b was never stalled while master a owned the bus");
        if (pair_acc[1] <= pair_resp[0])
            fail_run("master b was accepted before master a had its response");

        if (dut0.u_arbiter.u_arb_props.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_run($sformatf("%0d arbiter assertion failures",
                               dut0.u_arbiter.u_arb_props.fail_count));
        end
    end

endmodule : soc_bus_tb

// ==== vlog.f ====
hdl/bus_pkg.sv
hdl/sysreg_pkg.sv
hdl/wb_priority_arbiter.sv
hdl/bus_decoder.sv
hdl/scratch_ram.sv
hdl/sysreg_block.sv
hdl/switch_led_port.sv
hdl/soc_bus_fabric.sv
verification/soc_bus_properties.sv
verification/soc_bus_tb.sv
